//--- design/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// word width for data and addresses
`define XLEN 32

`define NUM_REGS 32
`define REG_IDX_W 5

// ebreak, used as the halt instruction
`define EBREAK_CODE 32'h0010_0073

`endif

//--- design/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    // all-zero value is a nop
    typedef struct packed {
        alu_op_t               alu_op;
        logic                  use_imm;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch_eq;
        logic                  is_branch_ne;
        logic                  is_jal;
        logic                  is_halt;
        logic                  writes_rd;
        logic [`REG_IDX_W-1:0] rd;
    } dec_inst_t;

endpackage

//--- design/rv_fwd_if.sv
`timescale 1ns/1ns

// results flowing back from execute and writeback into decode
interface rv_fwd_if #(
    parameter int DATA_W = 32,
    parameter int IDX_W  = 5
);
    logic              ex_valid;
    logic              ex_is_load;
    logic [IDX_W-1:0]  ex_rd;
    logic [DATA_W-1:0] ex_result;
    logic              wb_valid;
    logic [IDX_W-1:0]  wb_rd;
    logic [DATA_W-1:0] wb_data;

    modport ex_src (output ex_valid, output ex_is_load, output ex_rd, output ex_result);
    modport wb_src (output wb_valid, output wb_rd, output wb_data);
    modport sink (
        input ex_valid, input ex_is_load, input ex_rd, input ex_result,
        input wb_valid, input wb_rd, input wb_data
    );
endinterface

//--- design/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic [`REG_IDX_W-1:0] rs1_idx,
    input  logic [`REG_IDX_W-1:0] rs2_idx,
    input  logic                  we,
    input  logic [`REG_IDX_W-1:0] wr_idx,
    input  logic [`XLEN-1:0]      wr_data,
    output logic [`XLEN-1:0]      rs1_data,
    output logic [`XLEN-1:0]      rs2_data
);
    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (we && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- design/rv_fetch.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_fetch (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,
    input  logic [`XLEN-1:0] prog_base,
    input  logic             stall,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    input  logic             halt_retire,
    output logic             busy,
    output logic [`XLEN-1:0] imem_addr,
    output logic             fetch_valid,
    output logic [`XLEN-1:0] fetch_pc
);
    logic [`XLEN-1:0] pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else if (!busy) begin
            fetch_valid <= 1'b0;
            // start of a run
            if (run) begin
                busy <= 1'b1;
                pc   <= prog_base;
            end
        end else begin
            if (halt_retire) begin
                busy <= 1'b0;
            end
            // redirect wins over a load-use stall
            if (redirect) begin
                pc <= redirect_pc;
            end else if (!stall) begin
                pc <= pc + `XLEN'd4;
            end
            // word in flight from the old path is not wanted
            if (redirect || halt_retire) begin
                fetch_valid <= 1'b0;
            end else if (!stall) begin
                fetch_valid <= 1'b1;
            end
        end
    end

    // pc of the word arriving from imem next cycle
    always_ff @(posedge clk) begin
        if (!stall) begin
            fetch_pc <= pc;
        end
    end

    assign imem_addr = pc;

    a_no_spurious_start: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy && !run) |=> !busy);

endmodule

//--- design/rv_decode.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  busy,
    input  logic                  fetch_valid,
    input  logic [`XLEN-1:0]      fetch_pc,
    input  logic [`XLEN-1:0]      imem_rdata,
    input  logic                  flush,
    rv_fwd_if.sink                fwd,
    input  logic [`XLEN-1:0]      rf_rs1_data,
    input  logic [`XLEN-1:0]      rf_rs2_data,
    output logic                  stall,
    output logic [`REG_IDX_W-1:0] rf_rs1_idx,
    output logic [`REG_IDX_W-1:0] rf_rs2_idx,
    output logic                  de_valid,
    output rv_pkg::dec_inst_t     de_inst,
    output logic [`XLEN-1:0]      de_pc,
    output logic [`XLEN-1:0]      de_rs1,
    output logic [`XLEN-1:0]      de_rs2,
    output logic [`XLEN-1:0]      de_imm
);
    logic             held;
    logic [`XLEN-1:0] hold_word;
    logic [`XLEN-1:0] inst_word;
    logic [2:0]       funct3;
    logic [6:0]       funct7;

    // imem has moved on during a stall, so keep our own copy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else begin
            held <= stall && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            hold_word <= inst_word;
        end
    end

    assign inst_word  = held ? hold_word : imem_rdata;
    assign funct3     = inst_word[14:12];
    assign funct7     = inst_word[31:25];
    assign rf_rs1_idx = inst_word[19:15];
    assign rf_rs2_idx = inst_word[24:20];

    always_comb begin
        de_inst        = '0;
        de_inst.alu_op = rv_pkg::ALU_ADD;
        de_inst.rd     = inst_word[11:7];
        de_imm         = '0;
        case (rv_pkg::opcode_t'(inst_word[6:0]))
            rv_pkg::OP: begin
                if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    de_inst.writes_rd = 1'b1;
                    case (funct3)
                        3'b000: de_inst.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                        3'b010: de_inst.alu_op = rv_pkg::ALU_SLT;
                        3'b100: de_inst.alu_op = rv_pkg::ALU_XOR;
                        3'b110: de_inst.alu_op = rv_pkg::ALU_OR;
                        3'b111: de_inst.alu_op = rv_pkg::ALU_AND;
                        default: de_inst.writes_rd = 1'b0;
                    endcase
                end
            end
            rv_pkg::OP_IMM: begin
                de_imm            = {{20{inst_word[31]}}, inst_word[31:20]};
                de_inst.use_imm   = (funct3 == 3'b000);
                de_inst.writes_rd = (funct3 == 3'b000);
            end
            rv_pkg::LOAD: begin
                de_imm            = {{20{inst_word[31]}}, inst_word[31:20]};
                de_inst.use_imm   = (funct3 == 3'b010);
                de_inst.is_load   = (funct3 == 3'b010);
                de_inst.writes_rd = (funct3 == 3'b010);
            end
            rv_pkg::STORE: begin
                de_imm           = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
                de_inst.use_imm  = (funct3 == 3'b010);
                de_inst.is_store = (funct3 == 3'b010);
            end
            rv_pkg::BRANCH: begin
                de_imm = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                          inst_word[30:25], inst_word[11:8], 1'b0};
                de_inst.is_branch_eq = (funct3 == 3'b000);
                de_inst.is_branch_ne = (funct3 == 3'b001);
            end
            rv_pkg::JAL: begin
                de_imm = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                          inst_word[20], inst_word[30:21], 1'b0};
                de_inst.is_jal    = 1'b1;
                de_inst.writes_rd = 1'b1;
            end
            // only the exact ebreak word halts
            rv_pkg::SYSTEM: de_inst.is_halt = (inst_word == `EBREAK_CODE);
            default: ;
        endcase
    end

    // newest result first
    always_comb begin
        if (fwd.ex_valid && fwd.ex_rd == rf_rs1_idx) begin
            de_rs1 = fwd.ex_result;
        end else if (fwd.wb_valid && fwd.wb_rd == rf_rs1_idx) begin
            de_rs1 = fwd.wb_data;
        end else begin
            de_rs1 = rf_rs1_data;
        end
        if (fwd.ex_valid && fwd.ex_rd == rf_rs2_idx) begin
            de_rs2 = fwd.ex_result;
        end else if (fwd.wb_valid && fwd.wb_rd == rf_rs2_idx) begin
            de_rs2 = fwd.wb_data;
        end else begin
            de_rs2 = rf_rs2_data;
        end
    end

    // load data is not ready until writeback
    assign stall = busy && fetch_valid && fwd.ex_valid && fwd.ex_is_load &&
                   (fwd.ex_rd == rf_rs1_idx || fwd.ex_rd == rf_rs2_idx);

    assign de_valid = busy && fetch_valid && !stall && !flush;
    assign de_pc    = fetch_pc;

    // the bubble sent on a stall clears it one cycle later
    a_stall_on_load: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> fwd.ex_is_load ##1 !stall);

endmodule

//--- design/rv_execute.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              busy,
    input  logic              de_valid,
    input  rv_pkg::dec_inst_t de_inst,
    input  logic [`XLEN-1:0]  de_pc,
    input  logic [`XLEN-1:0]  de_rs1,
    input  logic [`XLEN-1:0]  de_rs2,
    input  logic [`XLEN-1:0]  de_imm,
    rv_fwd_if.ex_src          fwd,
    output logic              redirect,
    output logic [`XLEN-1:0]  redirect_pc,
    output logic [`XLEN-1:0]  dmem_addr,
    output logic [`XLEN-1:0]  dmem_wdata,
    output logic              dmem_we,
    output logic              dmem_re,
    output logic              ex_valid,
    output rv_pkg::dec_inst_t ex_inst,
    output logic [`XLEN-1:0]  ex_result
);
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1;
    logic [`XLEN-1:0] rs2;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] opnd_b;
    logic [`XLEN-1:0] alu_out;
    logic             rs_equal;
    logic             taken;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= busy && de_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_inst <= de_inst;
        pc      <= de_pc;
        rs1     <= de_rs1;
        rs2     <= de_rs2;
        imm     <= de_imm;
    end

    assign opnd_b = ex_inst.use_imm ? imm : rs2;

    always_comb begin
        case (ex_inst.alu_op)
            rv_pkg::ALU_SUB: alu_out = rs1 - opnd_b;
            rv_pkg::ALU_AND: alu_out = rs1 & opnd_b;
            rv_pkg::ALU_OR:  alu_out = rs1 | opnd_b;
            rv_pkg::ALU_XOR: alu_out = rs1 ^ opnd_b;
            rv_pkg::ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(rs1) < $signed(opnd_b)};
            default:         alu_out = rs1 + opnd_b;
        endcase
    end

    // jal links to the next instruction
    assign ex_result = ex_inst.is_jal ? pc + `XLEN'd4 : alu_out;

    // halt also redirects so nothing younger reaches memory
    assign rs_equal = (rs1 == rs2);
    assign taken    = ex_inst.is_jal || ex_inst.is_halt ||
                      (ex_inst.is_branch_eq && rs_equal) ||
                      (ex_inst.is_branch_ne && !rs_equal);

    assign redirect    = ex_valid && taken;
    assign redirect_pc = pc + imm;

    assign dmem_addr  = alu_out;
    assign dmem_wdata = rs2;
    assign dmem_we    = ex_valid && ex_inst.is_store;
    assign dmem_re    = ex_valid && ex_inst.is_load;

    assign fwd.ex_valid   = ex_valid && ex_inst.writes_rd && (ex_inst.rd != '0);
    assign fwd.ex_is_load = ex_valid && ex_inst.is_load;
    assign fwd.ex_rd      = ex_inst.rd;
    assign fwd.ex_result  = ex_result;

    a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n) !(dmem_we && dmem_re));

endmodule

//--- design/rv_writeback.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_writeback (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  busy,
    input  logic                  ex_valid,
    input  rv_pkg::dec_inst_t     ex_inst,
    input  logic [`XLEN-1:0]      ex_result,
    input  logic [`XLEN-1:0]      dmem_rdata,
    rv_fwd_if.wb_src              fwd,
    output logic                  rf_we,
    output logic [`REG_IDX_W-1:0] rf_idx,
    output logic [`XLEN-1:0]      rf_data,
    output logic                  halt_retire
);
    logic              wb_valid;
    rv_pkg::dec_inst_t wb_inst;
    logic [`XLEN-1:0]  wb_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= busy && ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_inst   <= ex_inst;
        wb_result <= ex_result;
    end

    // dmem answers during this cycle for a load
    assign rf_data = wb_inst.is_load ? dmem_rdata : wb_result;
    assign rf_we   = wb_valid && wb_inst.writes_rd;
    assign rf_idx  = wb_inst.rd;

    assign halt_retire = wb_valid && wb_inst.is_halt;

    assign fwd.wb_valid = rf_we && (wb_inst.rd != '0);
    assign fwd.wb_rd    = wb_inst.rd;
    assign fwd.wb_data  = rf_data;

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,
    input  logic [`XLEN-1:0] prog_base,
    output logic             busy,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_rdata,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    output logic             dmem_we,
    output logic             dmem_re,
    input  logic [`XLEN-1:0] dmem_rdata
);
    logic                  fetch_valid;
    logic [`XLEN-1:0]      fetch_pc;
    logic                  stall;
    logic                  redirect;
    logic [`XLEN-1:0]      redirect_pc;
    logic                  halt_retire;
    logic [`REG_IDX_W-1:0] rf_rs1_idx;
    logic [`REG_IDX_W-1:0] rf_rs2_idx;
    logic [`XLEN-1:0]      rf_rs1_data;
    logic [`XLEN-1:0]      rf_rs2_data;
    logic                  rf_we;
    logic [`REG_IDX_W-1:0] rf_idx;
    logic [`XLEN-1:0]      rf_data;
    logic                  de_valid;
    rv_pkg::dec_inst_t     de_inst;
    logic [`XLEN-1:0]      de_pc;
    logic [`XLEN-1:0]      de_rs1;
    logic [`XLEN-1:0]      de_rs2;
    logic [`XLEN-1:0]      de_imm;
    logic                  ex_valid;
    rv_pkg::dec_inst_t     ex_inst;
    logic [`XLEN-1:0]      ex_result;

    rv_fwd_if #(.DATA_W(`XLEN), .IDX_W(`REG_IDX_W)) fwd ();

    rv_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .run(run), .prog_base(prog_base),
        .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
        .halt_retire(halt_retire), .busy(busy), .imem_addr(imem_addr),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc)
    );

    rv_regfile u_regfile (
        .clk(clk), .rs1_idx(rf_rs1_idx), .rs2_idx(rf_rs2_idx),
        .we(rf_we), .wr_idx(rf_idx), .wr_data(rf_data),
        .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data)
    );

    // a taken branch in execute flushes decode
    rv_decode u_decode (
        .clk(clk), .rst_n(rst_n), .busy(busy), .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc), .imem_rdata(imem_rdata), .flush(redirect), .fwd(fwd.sink),
        .rf_rs1_data(rf_rs1_data), .rf_rs2_data(rf_rs2_data), .stall(stall),
        .rf_rs1_idx(rf_rs1_idx), .rf_rs2_idx(rf_rs2_idx), .de_valid(de_valid),
        .de_inst(de_inst), .de_pc(de_pc), .de_rs1(de_rs1), .de_rs2(de_rs2), .de_imm(de_imm)
    );

    rv_execute u_execute (
        .clk(clk), .rst_n(rst_n), .busy(busy), .de_valid(de_valid), .de_inst(de_inst),
        .de_pc(de_pc), .de_rs1(de_rs1), .de_rs2(de_rs2), .de_imm(de_imm), .fwd(fwd.ex_src),
        .redirect(redirect), .redirect_pc(redirect_pc), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_we(dmem_we), .dmem_re(dmem_re),
        .ex_valid(ex_valid), .ex_inst(ex_inst), .ex_result(ex_result)
    );

    rv_writeback u_writeback (
        .clk(clk), .rst_n(rst_n), .busy(busy), .ex_valid(ex_valid), .ex_inst(ex_inst),
        .ex_result(ex_result), .dmem_rdata(dmem_rdata), .fwd(fwd.wb_src),
        .rf_we(rf_we), .rf_idx(rf_idx), .rf_data(rf_data), .halt_retire(halt_retire)
    );

endmodule

//--- verification/tb_rv_core.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_rv_core;

    localparam logic [31:0] BASE_A = 32'h0000_0000;
    localparam logic [31:0] BASE_B = 32'h0000_0400;

    logic             clk;
    logic             rst_n;
    logic             run;
    logic [`XLEN-1:0] prog_base;
    logic             busy;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_rdata = '0;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic             dmem_we;
    logic             dmem_re;
    logic [`XLEN-1:0] dmem_rdata = '0;

    logic [31:0] imem [0:511];
    logic [31:0] dmem [0:255];
    // ISA-level state of the reference model
    logic [31:0] ref_mem [0:255];
    logic [31:0] ref_regs [0:31];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] lcg_state = 32'h4676a712;
    logic [8:0]  wr_ptr;
    int          len_a;
    int          len_b;
    int          cycles = 0;
    int          cycle_limit = 100000;

    rv_core UUT (
        .clk(clk), .rst_n(rst_n), .run(run), .prog_base(prog_base), .busy(busy),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_we(dmem_we), .dmem_re(dmem_re),
        .dmem_rdata(dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // signed 12-bit immediate
    function automatic int rand_imm();
        return int'(lcg_next() >> 20) - 2048;
    endfunction

    function automatic int rand_reg();
        return 16 + int'((lcg_next() >> 16) % 32'd8);
    endfunction

    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] opc);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic logic [31:0] sw_word(input int imm, input int rs2, input int rs1);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] branch_word(input int off, input int rs2, input int rs1,
                                                input int f3);
        logic [12:0] v;
        v = 13'(off);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal_word(input int off, input int rd);
        logic [20:0] v;
        v = 21'(off);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[wr_ptr] = w;
        wr_ptr = wr_ptr + 9'd1;
    endtask

    task automatic build_programs();
        int op;
        int rd;
        for (int i = 0; i < 512; i++) begin
            imem[9'(i)] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[8'(i)] = lcg_next();
            ref_mem[8'(i)] = dmem[8'(i)];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[5'(i)] = '0;
        end
        // program A: dependent chain, each result feeds the next
        wr_ptr = BASE_A[10:2];
        emit(i_type(rand_imm(), 0, 0, 1, 7'h13));
        emit(i_type(rand_imm(), 1, 0, 2, 7'h13));
        emit(r_type(0, 1, 2, 0, 3));
        emit(r_type(32, 1, 3, 0, 4));
        emit(r_type(0, 2, 4, 4, 5));
        emit(r_type(0, 3, 5, 6, 6));
        emit(r_type(0, 4, 6, 7, 7));
        emit(r_type(0, 1, 7, 2, 8));
        for (int k = 8; k >= 1; k--) begin
            emit(sw_word(4 * k, k, 0));
        end
        // load followed at once by a use
        emit(i_type(64, 0, 2, 9, 7'h03));
        emit(r_type(0, 1, 9, 0, 10));
        emit(sw_word(68, 10, 0));
        emit(i_type(72, 0, 2, 11, 7'h03));
        emit(sw_word(76, 11, 0));
        // slli is outside the subset and must leave x1 alone
        emit(i_type(1, 1, 1, 1, 7'h13));
        emit(sw_word(80, 1, 0));
        // branches and jal, wrong-path stores in between
        emit(i_type(5, 0, 0, 12, 7'h13));
        emit(i_type(5, 0, 0, 13, 7'h13));
        emit(branch_word(12, 13, 12, 0));
        emit(sw_word(100, 1, 0));
        emit(sw_word(104, 2, 0));
        emit(branch_word(12, 13, 12, 1));
        emit(sw_word(108, 3, 0));
        emit(branch_word(8, 0, 12, 0));
        emit(sw_word(112, 4, 0));
        emit(branch_word(8, 0, 12, 1));
        emit(sw_word(116, 5, 0));
        emit(jal_word(12, 14));
        emit(sw_word(120, 6, 0));
        emit(sw_word(124, 7, 0));
        emit(sw_word(128, 14, 0));
        emit(branch_word(8, 11, 9, 0));
        emit(sw_word(132, 8, 0));
        emit(`EBREAK_CODE);
        len_a = int'(wr_ptr) - int'(BASE_A[10:2]);
        // program B: random ALU mix on x16..x23
        wr_ptr = BASE_B[10:2];
        for (int r = 16; r < 24; r++) begin
            emit(i_type(rand_imm(), 0, 0, r, 7'h13));
        end
        for (int k = 0; k < 12; k++) begin
            op = int'((lcg_next() >> 16) % 32'd7);
            rd = rand_reg();
            case (op)
                0: emit(r_type(0, rand_reg(), rand_reg(), 0, rd));
                1: emit(r_type(32, rand_reg(), rand_reg(), 0, rd));
                2: emit(r_type(0, rand_reg(), rand_reg(), 7, rd));
                3: emit(r_type(0, rand_reg(), rand_reg(), 6, rd));
                4: emit(r_type(0, rand_reg(), rand_reg(), 4, rd));
                5: emit(r_type(0, rand_reg(), rand_reg(), 2, rd));
                default: emit(i_type(rand_imm(), rand_reg(), 0, rd, 7'h13));
            endcase
            emit(sw_word(160 + 4 * k, rd, 0));
        end
        // reads a word written by program A
        emit(i_type(68, 0, 2, 24, 7'h03));
        emit(r_type(0, 16, 24, 0, 25));
        emit(sw_word(240, 25, 0));
        emit(`EBREAK_CODE);
        len_b = int'(wr_ptr) - int'(BASE_B[10:2]);
    endtask

    // ISA-level interpreter, queues every store in program order
    function automatic int ref_run(input logic [31:0] base);
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        logic [31:0] res;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        wen;
        logic        done;
        int          n;
        int          steps;
        pc = base;
        n = 0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 4096) begin
            w = imem[pc[10:2]];
            f3 = w[14:12];
            f7 = w[31:25];
            a = ref_regs[w[19:15]];
            b = ref_regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            next_pc = pc + 32'd4;
            wen = 1'b0;
            res = '0;
            case (w[6:0])
                7'h33: begin
                    if (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd0)) begin
                        wen = 1'b1;
                        case (f3)
                            3'd0: res = f7[5] ? a - b : a + b;
                            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            3'd4: res = a ^ b;
                            3'd6: res = a | b;
                            3'd7: res = a & b;
                            default: wen = 1'b0;
                        endcase
                    end
                end
                7'h13: begin
                    wen = (f3 == 3'd0);
                    res = a + imm_i;
                end
                7'h03: begin
                    ea = a + imm_i;
                    wen = (f3 == 3'd2);
                    res = ref_mem[ea[9:2]];
                end
                7'h23: begin
                    if (f3 == 3'd2) begin
                        ea = a + imm_s;
                        ref_mem[ea[9:2]] = b;
                        exp_addr.push_back(ea);
                        exp_data.push_back(b);
                        n++;
                    end
                end
                7'h63: begin
                    if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                        next_pc = pc + imm_b;
                    end
                end
                7'h6f: begin
                    wen = 1'b1;
                    res = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                7'h73: done = (w == `EBREAK_CODE);
                default: ;
            endcase
            if (wen && w[11:7] != 5'd0) begin
                ref_regs[w[11:7]] = res;
            end
            pc = next_pc;
            steps++;
        end
        return n;
    endfunction

    // both memories answer one cycle after the address edge
    always @(posedge clk) begin
        imem_rdata <= imem[imem_addr[10:2]];
        if (dmem_re) begin
            dmem_rdata <= dmem[dmem_addr[9:2]];
        end else begin
            // no read strobe, so only junk comes back
            dmem_rdata <= ~dmem_addr;
        end
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    always @(negedge clk) begin
        if (rst_n && dmem_we) begin
            assert (exp_addr.size() > 0)
            else abort_run($sformatf("unexpected store to %h at %0t", dmem_addr, $time));
            if (exp_addr.size() > 0) begin
                assert (dmem_addr == exp_addr[0])
                else abort_run($sformatf("mismatch at %0t: dmem_addr got %h expected %h",
                                         $time, dmem_addr, exp_addr[0]));
                assert (dmem_wdata == exp_data[0])
                else abort_run($sformatf("mismatch at %0t: dmem_wdata got %h expected %h",
                                         $time, dmem_wdata, exp_data[0]));
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        assert (cycles < cycle_limit)
        else abort_run($sformatf("timeout after %0d cycles, core never finished", cycles));
    end

    task automatic execute_program(input logic [31:0] base);
        int n;
        n = ref_run(base);
        @(negedge clk);
        run = 1'b1;
        prog_base = base;
        @(negedge clk);
        run = 1'b0;
        assert (busy) else abort_run("busy did not rise after the run pulse");
        assert (imem_addr == base)
        else abort_run($sformatf("mismatch at %0t: imem_addr got %h expected %h",
                                 $time, imem_addr, base));
        while (busy) begin
            @(negedge clk);
        end
        assert (exp_addr.size() == 0)
        else abort_run($sformatf("core halted with %0d of %0d expected stores missing",
                                 exp_addr.size(), n));
    endtask

    initial begin
        rst_n = 1'b0;
        run = 1'b0;
        prog_base = '0;
        build_programs();
        cycle_limit = 10 * (len_a + len_b) + 200;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        // idle until the first run pulse
        repeat (8) begin
            @(negedge clk);
            assert (!busy && !dmem_we && !dmem_re)
            else abort_run("core left idle before any run pulse");
        end
        execute_program(BASE_A);
        execute_program(BASE_B);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- rv_core.f
+incdir+design
design/rv_pkg.sv
design/rv_fwd_if.sv
design/rv_regfile.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_core.sv
verification/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
